// ==== include/dma_settings.svh ====
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// Transfer geometry
`define DMA_LINE_BYTES 16
`define DMA_LINE_OFS_W 4
`define DMA_DISC_ADDR_W 32
`define DMA_MEM_ADDR_W 15
`define DMA_COUNT_W 12

// Register map
`define DMA_REG_ADDR_W 8
`define DMA_REG_KBCHAR 8'h00
`define DMA_REG_SOURCE 8'h04
`define DMA_REG_DEST 8'h08
`define DMA_REG_COUNT 8'h0C
`define DMA_REG_CONTROL 8'h10
`define DMA_REG_STATUS 8'h14

`endif

// ==== logic/dmaPkg.sv ====
`include "dma_settings.svh"

package dmaPkg;

    // AXI4-Lite register bus
    typedef struct packed {
        logic awValid;
        logic [`DMA_REG_ADDR_W-1:0] awAddr;
        logic wValid;
        logic [31:0] wData;
        logic [3:0] wStrb;
        logic bReady;
    } axiWriteReq;

    typedef struct packed {
        logic awReady;
        logic wReady;
        logic bValid;
        logic [1:0] bResp;
    } axiWriteRsp;

    typedef struct packed {
        logic arValid;
        logic [`DMA_REG_ADDR_W-1:0] arAddr;
        logic rReady;
    } axiReadReq;

    typedef struct packed {
        logic arReady;
        logic rValid;
        logic [31:0] rData;
        logic [1:0] rResp;
    } axiReadRsp;

    // Job as programmed by the CPU
    typedef struct packed {
        logic [`DMA_DISC_ADDR_W-1:0] discSource;
        logic [`DMA_MEM_ADDR_W-1:0] memDest;
        logic [`DMA_COUNT_W-1:0] byteCount;
    } dmaJob;

    typedef struct packed {
        logic valid;
        logic [`DMA_DISC_ADDR_W-`DMA_LINE_OFS_W-1:0] lineAddr;
    } discReq;

    typedef struct packed {
        logic valid;
        logic [`DMA_LINE_BYTES*8-1:0] data;
    } discRsp;

    typedef struct packed {
        logic valid;
        logic [`DMA_LINE_BYTES*8-1:0] data;
    } lineBeat;

    typedef struct packed {
        logic valid;
        logic [`DMA_MEM_ADDR_W-1:0] addr;
        logic [`DMA_LINE_BYTES*8-1:0] data;
        logic [`DMA_LINE_BYTES-1:0] strobe;
    } memWrite;

endpackage

// ==== logic/dmaRegDecode.sv ====
`include "dma_settings.svh"

module dmaRegDecode (
    input  logic clk,
    input  logic rst,
    input  dmaPkg::axiWriteReq wrReq,
    output dmaPkg::axiWriteRsp wrRsp,
    input  dmaPkg::axiReadReq rdReq,
    output dmaPkg::axiReadRsp rdRsp,
    input  logic [7:0] kbData,
    output logic kbRead,
    input  logic busy,
    input  logic irq,
    output dmaPkg::dmaJob job,
    output logic jobStart,
    output logic irqClear
);

    localparam logic [1:0] RespOkay = 2'b00;
    localparam logic [1:0] RespSlvErr = 2'b10;

    logic bValid;
    logic [1:0] bResp;
    logic rValid;
    logic [1:0] rResp;
    logic [31:0] rData;
    logic wrAccept;
    logic rdAccept;
    logic wrKnown;
    logic wrError;
    logic rdKnown;
    logic [31:0] rdWord;

    // Address and data taken together, one write response at a time
    assign wrAccept = wrReq.awValid && wrReq.wValid && !bValid;
    assign rdAccept = rdReq.arValid && !rValid;

    assign wrRsp.awReady = wrAccept;
    assign wrRsp.wReady = wrAccept;
    assign wrRsp.bValid = bValid;
    assign wrRsp.bResp = bResp;

    assign rdRsp.arReady = !rValid;
    assign rdRsp.rValid = rValid;
    assign rdRsp.rData = rData;
    assign rdRsp.rResp = rResp;

    // KBCHAR is read-only, so it is not a write target
    always_comb begin
        case (wrReq.awAddr)
            `DMA_REG_SOURCE, `DMA_REG_DEST, `DMA_REG_COUNT,
            `DMA_REG_CONTROL, `DMA_REG_STATUS: wrKnown = 1'b1;
            default: wrKnown = 1'b0;
        endcase
    end

    assign wrError = !wrKnown || (wrReq.awAddr == `DMA_REG_CONTROL && busy);

    always_ff @(posedge clk) begin
        if (!rst) begin
            bValid <= 1'b0;
            bResp <= RespOkay;
            jobStart <= 1'b0;
            irqClear <= 1'b0;
            job <= '0;
        end else begin
            jobStart <= 1'b0;
            irqClear <= 1'b0;
            if (bValid && wrReq.bReady) begin
                bValid <= 1'b0;
            end
            if (wrAccept) begin
                bValid <= 1'b1;
                bResp <= wrError ? RespSlvErr : RespOkay;
                if (!wrError) begin
                    case (wrReq.awAddr)
                        `DMA_REG_SOURCE: job.discSource <= wrReq.wData;
                        `DMA_REG_DEST: job.memDest <= wrReq.wData[`DMA_MEM_ADDR_W-1:0];
                        `DMA_REG_COUNT: job.byteCount <= wrReq.wData[`DMA_COUNT_W-1:0];
                        // Zero-length job never starts
                        `DMA_REG_CONTROL: jobStart <= wrReq.wData[0] && job.byteCount != '0;
                        `DMA_REG_STATUS: irqClear <= wrReq.wData[1];
                        default: ;
                    endcase
                end
            end
        end
    end

    always_comb begin
        rdKnown = 1'b1;
        case (rdReq.arAddr)
            `DMA_REG_KBCHAR: rdWord = {24'b0, kbData};
            `DMA_REG_SOURCE: rdWord = job.discSource;
            `DMA_REG_DEST: rdWord = 32'(job.memDest);
            `DMA_REG_COUNT: rdWord = 32'(job.byteCount);
            `DMA_REG_CONTROL: rdWord = {31'b0, busy};
            `DMA_REG_STATUS: rdWord = {30'b0, irq, busy};
            default: begin
                rdKnown = 1'b0;
                rdWord = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            rValid <= 1'b0;
            rResp <= RespOkay;
            kbRead <= 1'b0;
        end else begin
            // Character consumed on the cycle after the read is taken
            kbRead <= rdAccept && rdReq.arAddr == `DMA_REG_KBCHAR;
            if (rValid && rdReq.rReady) begin
                rValid <= 1'b0;
            end
            if (rdAccept) begin
                rValid <= 1'b1;
                rResp <= rdKnown ? RespOkay : RespSlvErr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdAccept) begin
            rData <= rdWord;
        end
    end

    bHeldUntilReady: assert property (@(posedge clk) disable iff (!rst)
        wrRsp.bValid && !wrReq.bReady |=> wrRsp.bValid && $stable(wrRsp.bResp));

endmodule

// ==== logic/dmaSequencer.sv ====
`include "dma_settings.svh"

module dmaSequencer (
    input  logic clk,
    input  logic rst,
    input  dmaPkg::dmaJob job,
    input  logic jobStart,
    input  logic irqClear,
    output dmaPkg::discReq disc,
    input  logic discReady,
    input  dmaPkg::discRsp discData,
    output dmaPkg::lineBeat beat,
    input  logic lineReady,
    input  logic alignDone,
    output logic busy,
    output logic irq
);

    localparam int LineAddrW = `DMA_DISC_ADDR_W - `DMA_LINE_OFS_W;
    localparam int LineCntW = `DMA_COUNT_W - `DMA_LINE_OFS_W + 1;
    localparam int LineW = `DMA_LINE_BYTES * 8;

    logic [LineAddrW-1:0] lineAddr;
    logic [LineCntW-1:0] linesLeft;
    logic [LineCntW-1:0] jobLines;
    logic reqValid;
    logic waiting;
    logic bufValid;
    logic [LineW-1:0] bufData;
    logic reqDone;
    logic respIn;
    logic issue;

    // Disc reads needed, rounded up to whole lines
    assign jobLines = LineCntW'(({1'b0, job.byteCount} + (`DMA_LINE_BYTES - 1))
        >> `DMA_LINE_OFS_W);

    assign disc.valid = reqValid;
    assign disc.lineAddr = lineAddr;

    assign reqDone = reqValid && discReady;
    assign respIn = waiting && discData.valid;

    // Fresh response bypasses the buffer when it is empty
    assign beat.valid = bufValid || respIn;
    assign beat.data = bufValid ? bufData : discData.data;

    // Next read once nothing is in flight and the buffer is free or draining
    assign issue = busy && linesLeft != '0 && !reqValid
        && (!waiting || (respIn && lineReady))
        && (!bufValid || lineReady);

    always_ff @(posedge clk) begin
        if (!rst) begin
            reqValid <= 1'b0;
            waiting <= 1'b0;
            bufValid <= 1'b0;
            linesLeft <= '0;
            lineAddr <= '0;
            busy <= 1'b0;
            irq <= 1'b0;
        end else begin
            if (jobStart) begin
                busy <= 1'b1;
                reqValid <= 1'b1;
                lineAddr <= job.discSource[`DMA_DISC_ADDR_W-1:`DMA_LINE_OFS_W];
                linesLeft <= jobLines;
            end else begin
                if (reqDone) begin
                    reqValid <= 1'b0;
                    waiting <= 1'b1;
                    lineAddr <= lineAddr + 1'b1;
                    linesLeft <= linesLeft - 1'b1;
                end else if (issue) begin
                    reqValid <= 1'b1;
                end
                if (respIn) begin
                    waiting <= 1'b0;
                end
            end

            if (respIn && !lineReady) begin
                bufValid <= 1'b1;
            end else if (bufValid && lineReady) begin
                bufValid <= 1'b0;
            end

            if (alignDone) begin
                busy <= 1'b0;
                irq <= 1'b1;
            end else if (irqClear) begin
                irq <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (respIn && !lineReady) begin
            bufData <= discData.data;
        end
    end

    discOnlyWhileBusy: assert property (@(posedge clk) disable iff (!rst)
        disc.valid |-> busy);

endmodule

// ==== logic/dmaLineAligner.sv ====
`include "dma_settings.svh"

module dmaLineAligner (
    input  logic clk,
    input  logic rst,
    input  dmaPkg::dmaJob job,
    input  logic jobStart,
    input  dmaPkg::lineBeat beat,
    output logic lineReady,
    output dmaPkg::memWrite mem,
    input  logic memReady,
    output logic alignDone
);

    localparam int OfsW = `DMA_LINE_OFS_W;
    localparam int LineW = `DMA_LINE_BYTES * 8;
    localparam int PosW = `DMA_COUNT_W + 1;
    localparam int LineCntW = `DMA_COUNT_W - OfsW + 1;
    localparam int MemLineW = `DMA_MEM_ADDR_W - OfsW;

    logic [OfsW-1:0] offset;
    logic [MemLineW-1:0] nextLine;
    logic [LineCntW-1:0] linesLeft;
    logic [LineCntW-1:0] jobLines;
    // Destination bytes still to cover, counted from the current line start
    logic [PosW-1:0] posLeft;
    logic firstWrite;
    logic memValid;
    logic memLast;
    logic [`DMA_MEM_ADDR_W-1:0] memAddr;
    logic [LineW-1:0] memData;
    logic [`DMA_LINE_BYTES-1:0] memStrobe;
    logic [LineW-1:0] carry;
    logic [2*LineW-1:0] shifted;
    logic [`DMA_LINE_BYTES-1:0] strobe;
    logic slotFree;
    logic takeBeat;
    logic takeFlush;

    assign jobLines = LineCntW'(({1'b0, job.byteCount} + (`DMA_LINE_BYTES - 1)) >> OfsW);

    assign slotFree = !memValid || memReady;
    assign lineReady = linesLeft != '0 && slotFree;
    assign takeBeat = beat.valid && lineReady;
    // Leftover carry bytes after the last disc line
    assign takeFlush = linesLeft == '0 && posLeft != '0 && slotFree;
    assign alignDone = memValid && memReady && memLast;

    assign mem.valid = memValid;
    assign mem.addr = memAddr;
    assign mem.data = memData;
    assign mem.strobe = memStrobe;

    // Upper half spills into the next write
    assign shifted = {{LineW{1'b0}}, beat.data} << {offset, 3'b000};

    always_comb begin
        for (int i = 0; i < `DMA_LINE_BYTES; i++) begin
            strobe[i] = PosW'(i) < posLeft && (!firstWrite || OfsW'(i) >= offset);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            memValid <= 1'b0;
            memLast <= 1'b0;
            linesLeft <= '0;
            posLeft <= '0;
            firstWrite <= 1'b0;
            offset <= '0;
            nextLine <= '0;
        end else if (jobStart) begin
            linesLeft <= jobLines;
            posLeft <= PosW'(job.memDest[OfsW-1:0]) + PosW'(job.byteCount);
            firstWrite <= 1'b1;
            offset <= job.memDest[OfsW-1:0];
            nextLine <= job.memDest[`DMA_MEM_ADDR_W-1:OfsW];
        end else begin
            if (memReady) begin
                memValid <= 1'b0;
            end
            if (takeBeat || takeFlush) begin
                memValid <= 1'b1;
                memLast <= posLeft <= PosW'(`DMA_LINE_BYTES);
                firstWrite <= 1'b0;
                nextLine <= nextLine + 1'b1;
                if (posLeft <= PosW'(`DMA_LINE_BYTES)) begin
                    posLeft <= '0;
                end else begin
                    posLeft <= posLeft - PosW'(`DMA_LINE_BYTES);
                end
            end
            if (takeBeat) begin
                linesLeft <= linesLeft - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (jobStart) begin
            carry <= '0;
        end else if (takeBeat || takeFlush) begin
            memAddr <= {nextLine, {OfsW{1'b0}}};
            memStrobe <= strobe;
            memData <= takeBeat ? (shifted[LineW-1:0] | carry) : carry;
            if (takeBeat) begin
                carry <= shifted[2*LineW-1:LineW];
            end
        end
    end

    noEmptyWrite: assert property (@(posedge clk) disable iff (!rst)
        mem.valid |-> mem.strobe != '0);

endmodule

// ==== logic/dmaTop.sv ====
module dmaTop (
    input  logic clk,
    input  logic rst,
    input  dmaPkg::axiWriteReq wrReq,
    output dmaPkg::axiWriteRsp wrRsp,
    input  dmaPkg::axiReadReq rdReq,
    output dmaPkg::axiReadRsp rdRsp,
    input  logic [7:0] kbData,
    output logic kbRead,
    output dmaPkg::discReq disc,
    input  logic discReady,
    input  dmaPkg::discRsp discData,
    output dmaPkg::memWrite mem,
    input  logic memReady,
    output logic irq
);

    dmaPkg::dmaJob job;
    dmaPkg::lineBeat beat;
    logic jobStart;
    logic irqClear;
    logic busy;
    logic lineReady;
    logic alignDone;

    dmaRegDecode i_regDecode (
        .clk(clk),
        .rst(rst),
        .wrReq(wrReq),
        .wrRsp(wrRsp),
        .rdReq(rdReq),
        .rdRsp(rdRsp),
        .kbData(kbData),
        .kbRead(kbRead),
        .busy(busy),
        .irq(irq),
        .job(job),
        .jobStart(jobStart),
        .irqClear(irqClear)
    );

    // Disc reads and completion
    dmaSequencer i_sequencer (
        .clk(clk),
        .rst(rst),
        .job(job),
        .jobStart(jobStart),
        .irqClear(irqClear),
        .disc(disc),
        .discReady(discReady),
        .discData(discData),
        .beat(beat),
        .lineReady(lineReady),
        .alignDone(alignDone),
        .busy(busy),
        .irq(irq)
    );

    dmaLineAligner i_aligner (
        .clk(clk),
        .rst(rst),
        .job(job),
        .jobStart(jobStart),
        .beat(beat),
        .lineReady(lineReady),
        .mem(mem),
        .memReady(memReady),
        .alignDone(alignDone)
    );

endmodule

// ==== testbench/dmaTbDevices.sv ====
`include "dma_settings.svh"

// Disc responder, one line per request after 1 to 8 cycles
module dmaTbDisc (
    input  logic clk,
    input  dmaPkg::discReq disc,
    output logic discReady,
    output dmaPkg::discRsp discData
);

    logic pending;
    int delay;
    logic [`DMA_DISC_ADDR_W-1:0] lineBase;

    // Byte stored at disc address a
    function automatic logic [7:0] discByte(input logic [31:0] a);
        logic [31:0] h;
        h = a * 32'h9E3779B1;
        return h[31:24] ^ a[7:0];
    endfunction

    initial begin
        discReady = 1'b0;
        discData = '0;
        pending = 1'b0;
        delay = 0;
        lineBase = '0;
        forever begin
            @(negedge clk);
            discData.valid = 1'b0;
            if (pending) begin
                if (delay == 0) begin
                    discData.valid = 1'b1;
                    for (int i = 0; i < `DMA_LINE_BYTES; i++) begin
                        discData.data[8*i +: 8] = discByte(lineBase + i);
                    end
                    pending = 1'b0;
                end else begin
                    delay--;
                end
            end
            discReady = ($urandom % 8) < 5;
            // Taken on the coming rising edge
            if (disc.valid && discReady) begin
                pending = 1'b1;
                lineBase = {disc.lineAddr, 4'b0000};
                delay = $urandom % 8;
            end
        end
    end

endmodule

// Byte-strobed memory with random back-pressure
module dmaTbMemory (
    input  logic clk,
    input  dmaPkg::memWrite mem,
    output logic memReady
);

    logic [7:0] store [0:(1 << `DMA_MEM_ADDR_W) - 1];
    int writeCount;

    initial begin
        for (int a = 0; a < (1 << `DMA_MEM_ADDR_W); a++) begin
            store[a] = 8'(a ^ (a >> 7)) ^ 8'h3C;
        end
        memReady = 1'b0;
        writeCount = 0;
        forever begin
            @(negedge clk);
            memReady = ($urandom % 4) != 0;
            if (mem.valid && memReady) begin
                writeCount++;
                for (int i = 0; i < `DMA_LINE_BYTES; i++) begin
                    if (mem.strobe[i]) begin
                        store[mem.addr + i] = mem.data[8*i +: 8];
                    end
                end
            end
        end
    end

endmodule

// ==== testbench/dmaTb.sv ====
`include "dma_settings.svh"

module dmaTb;

    localparam logic [1:0] RespOkay = 2'b00;
    localparam logic [1:0] RespSlvErr = 2'b10;

    logic clk;
    logic rst;
    dmaPkg::axiWriteReq wrReq;
    dmaPkg::axiWriteRsp wrRsp;
    dmaPkg::axiReadReq rdReq;
    dmaPkg::axiReadRsp rdRsp;
    logic [7:0] kbData;
    logic kbRead;
    dmaPkg::discReq disc;
    logic discReady;
    dmaPkg::discRsp discData;
    dmaPkg::memWrite mem;
    logic memReady;
    logic irq;

    int checks;
    int failures;
    int testsRun;
    int testsFailed;
    int kbPulses;
    int wrAccepts;
    int rdAccepts;
    bit stalled;
    logic [7:0] expWin [0:4127];

    dmaTop i_dut (.*);
    dmaTbDisc i_disc (.*);
    dmaTbMemory i_mem (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (kbRead) begin
            kbPulses <= kbPulses + 1;
        end
        // Address and data taken on the same edge
        if (wrReq.awValid && wrReq.wValid && wrRsp.awReady && wrRsp.wReady) begin
            wrAccepts <= wrAccepts + 1;
        end
        if (rdReq.arValid && rdRsp.arReady) begin
            rdAccepts <= rdAccepts + 1;
        end
    end

    // Same byte function as the disc model
    function automatic logic [7:0] discByteAt(input logic [31:0] a);
        logic [31:0] h;
        h = a * 32'h9E3779B1;
        return h[31:24] ^ a[7:0];
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
            input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            failures++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic reportStall(input string what);
        stalled = 1'b1;
        $display("Timeout: no %s within the cycle limit", what);
    endtask

    task automatic writeExpect(input logic [7:0] addr, input logic [31:0] data,
            input logic [1:0] expResp, input string name);
        int n;
        int accepts;
        if (stalled) return;
        accepts = wrAccepts;
        wrReq.awValid = 1'b1;
        wrReq.wValid = 1'b1;
        wrReq.awAddr = addr;
        wrReq.wData = data;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wrRsp.bValid && n < 50);
        wrReq.awValid = 1'b0;
        wrReq.wValid = 1'b0;
        if (!wrRsp.bValid) begin
            reportStall({name, " write response"});
        end else begin
            checkValue({name, " bResp"}, wrRsp.bResp, expResp);
            checkValue({name, " write handshakes"}, wrAccepts - accepts, 1);
        end
    endtask

    task automatic readExpect(input logic [7:0] addr, input logic [31:0] expected,
            input logic [1:0] expResp, input string name);
        int n;
        int accepts;
        if (stalled) return;
        accepts = rdAccepts;
        rdReq.arValid = 1'b1;
        rdReq.arAddr = addr;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!rdRsp.rValid && n < 50);
        rdReq.arValid = 1'b0;
        if (!rdRsp.rValid) begin
            reportStall({name, " read response"});
        end else begin
            checkValue({name, " rResp"}, rdRsp.rResp, expResp);
            checkValue({name, " read handshakes"}, rdAccepts - accepts, 1);
            if (expResp == RespOkay) begin
                checkValue({name, " rData"}, rdRsp.rData, expected);
            end
        end
    endtask

    task automatic waitForIrq(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (irq !== level && !stalled && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (irq !== level && !stalled) begin
            reportStall(what);
        end
    endtask

    task automatic runJob(input logic [31:0] src, input int dest, input int count,
            input bit pokeBusy);
        int base;
        int startWrites;
        base = dest - 16;
        for (int i = 0; i < count + 32; i++) begin
            expWin[i] = i_mem.store[base + i];
        end
        // Source taken line-aligned with 16 guard bytes on each side
        for (int i = 0; i < count; i++) begin
            expWin[16 + i] = discByteAt({src[31:4], 4'b0000} + i);
        end
        startWrites = i_mem.writeCount;
        writeExpect(`DMA_REG_SOURCE, src, RespOkay, "SOURCE");
        writeExpect(`DMA_REG_DEST, dest, RespOkay, "DEST");
        writeExpect(`DMA_REG_COUNT, count, RespOkay, "COUNT");
        writeExpect(`DMA_REG_CONTROL, 1, RespOkay, "CONTROL");
        if (pokeBusy) begin
            // Busy rises two cycles after the start write is taken
            @(negedge clk);
            readExpect(`DMA_REG_STATUS, 1, RespOkay, "STATUS busy");
            writeExpect(`DMA_REG_CONTROL, 1, RespSlvErr, "CONTROL while busy");
        end
        waitForIrq(1'b1, 100000, "irq at end of transfer");
        checkValue("memory write count", i_mem.writeCount - startWrites,
            (dest % 16 + count + 15) / 16);
        for (int i = 0; i < count + 32; i++) begin
            checkValue($sformatf("mem[0x%0h]", base + i), i_mem.store[base + i], expWin[i]);
        end
        readExpect(`DMA_REG_STATUS, 2, RespOkay, "STATUS done");
        writeExpect(`DMA_REG_STATUS, 2, RespOkay, "STATUS clear");
        waitForIrq(1'b0, 10, "irq low after clear");
        readExpect(`DMA_REG_STATUS, 0, RespOkay, "STATUS cleared");
    endtask

    task automatic endTest(input string name, input int mark);
        testsRun++;
        if (failures != mark || stalled) begin
            testsFailed++;
        end
        $display("Test %0d %s: %0d failed checks", testsRun, name, failures - mark);
    endtask

    initial begin
        int mark;
        void'($urandom(2642));
        wrReq = '0;
        wrReq.wStrb = 4'hF;
        wrReq.bReady = 1'b1;
        rdReq = '0;
        rdReq.rReady = 1'b1;
        kbData = '0;
        rst = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        mark = failures;
        for (int j = 0; j < 20 && !stalled; j++) begin
            runJob($urandom, 16 * (1 + $urandom % 1780), 1 + $urandom % 4095, 1'b0);
        end
        endTest("aligned transfer", mark);

        mark = failures;
        for (int j = 0; j < 30 && !stalled; j++) begin
            runJob($urandom, 16 + $urandom % 28000, 1 + $urandom % 200, 1'b0);
        end
        endTest("unaligned transfer", mark);

        mark = failures;
        for (int j = 0; j < 10 && !stalled; j++) begin
            runJob($urandom, 16 + $urandom % 28000, 1 + $urandom % 4095, 1'b0);
        end
        endTest("memory write count", mark);

        mark = failures;
        for (int j = 0; j < 4 && !stalled; j++) begin
            runJob($urandom, 16 + $urandom % 28000, 100 + $urandom % 100, 1'b1);
        end
        writeExpect(8'h18, 0, RespSlvErr, "unknown write");
        writeExpect(`DMA_REG_KBCHAR, 0, RespSlvErr, "KBCHAR write");
        readExpect(8'h1C, 0, RespSlvErr, "unknown read");
        endTest("busy start and unknown address", mark);

        mark = failures;
        for (int j = 0; j < 8 && !stalled; j++) begin
            int pulses;
            kbData = 8'($urandom);
            pulses = kbPulses;
            readExpect(`DMA_REG_KBCHAR, {24'b0, kbData}, RespOkay, "KBCHAR");
            repeat (2) @(negedge clk);
            checkValue("kbRead pulses", kbPulses - pulses, 1);
        end
        endTest("keyboard read", mark);

        mark = failures;
        runJob($urandom, 16 + $urandom % 28000, 1 + $urandom % 200, 1'b0);
        // Short job left uncleared so irq is still set
        writeExpect(`DMA_REG_COUNT, 16, RespOkay, "COUNT");
        writeExpect(`DMA_REG_CONTROL, 1, RespOkay, "CONTROL");
        waitForIrq(1'b1, 10000, "irq at end of short transfer");
        // Reset while irq is set and a transfer runs
        writeExpect(`DMA_REG_COUNT, 160, RespOkay, "COUNT");
        writeExpect(`DMA_REG_CONTROL, 1, RespOkay, "CONTROL");
        repeat (3) @(negedge clk);
        checkValue("irq before reset", irq, 1);
        rst = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b1;
        checkValue("irq", irq, 0);
        readExpect(`DMA_REG_STATUS, 0, RespOkay, "STATUS after reset");
        endTest("interrupt clear and reset", mark);

        $display("%0d tests, %0d failed, %0d checks, %0d failed checks",
            testsRun, testsFailed, checks, failures);
        if (failures == 0 && !stalled) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+include
logic/dmaPkg.sv
logic/dmaRegDecode.sv
logic/dmaSequencer.sv
logic/dmaLineAligner.sv
logic/dmaTop.sv
testbench/dmaTbDevices.sv
testbench/dmaTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module dmaTb -o dmaSim \
    || exit 1
out="$(./obj_dir/dmaSim)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "^Result: PASSED$" && exit 0 || exit 1
